/* logic/periph_bus_bridge.sv */
// ==========================================================
// OBI target to register bridge with peripheral decode and
// a registered single-cycle response
// ==========================================================
`default_nettype none

module periph_bus_bridge
  import periph_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  input  wire obi_req_t obi_req_i,
  output obi_rsp_t      obi_rsp_o,
  output reg_req_t      irq_req_o,
  output reg_req_t      gpio_req_o,
  output reg_req_t      timer_req_o,
  input  wire reg_rsp_t irq_rsp_i,
  input  wire reg_rsp_t gpio_rsp_i,
  input  wire reg_rsp_t timer_rsp_i
);

  periph_sel_e       sel;
  reg_req_t          req_base;
  reg_rsp_t          rsp_sel;
  logic              rvalid_q;
  logic              err_q;
  logic [DATA_W-1:0] rdata_q;

  always_comb begin
    case (obi_req_i.addr[ADDR_W-1 -: SEL_W])
      SEL_IRQ:   sel = SEL_IRQ;
      SEL_GPIO:  sel = SEL_GPIO;
      SEL_TIMER: sel = SEL_TIMER;
      default:   sel = SEL_NONE;
    endcase
  end

  always_comb begin
    req_base.valid  = 1'b0;
    req_base.op     = obi_req_i.we ? REG_WRITE : REG_READ;
    req_base.offset = obi_req_i.addr[OFFSET_W-1:0];
    req_base.wdata  = obi_req_i.wdata;
    req_base.be     = obi_req_i.be;

    irq_req_o   = req_base;
    gpio_req_o  = req_base;
    timer_req_o = req_base;
    // Only the addressed peripheral sees valid
    irq_req_o.valid   = obi_req_i.req && (sel == SEL_IRQ);
    gpio_req_o.valid  = obi_req_i.req && (sel == SEL_GPIO);
    timer_req_o.valid = obi_req_i.req && (sel == SEL_TIMER);
  end

  always_comb begin
    case (sel)
      SEL_IRQ:   rsp_sel = irq_rsp_i;
      SEL_GPIO:  rsp_sel = gpio_rsp_i;
      SEL_TIMER: rsp_sel = timer_rsp_i;
      default:   rsp_sel = '{rdata: '0, error: 1'b1};
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= obi_req_i.req;
      err_q    <= obi_req_i.req && rsp_sel.error;
      rdata_q  <= rsp_sel.error ? '0 : rsp_sel.rdata;
    end
  end

  assign obi_rsp_o.gnt    = obi_req_i.req;
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.err    = err_q;
  assign obi_rsp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

/* logic/periph_gpio.sv */
// ==========================================================
// GPIO block with output and enable registers, synchronised
// inputs and rising-edge interrupt status
// ==========================================================
`default_nettype none

module periph_gpio
  import periph_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire reg_req_t          reg_req_i,
  output reg_rsp_t               reg_rsp_o,
  input  wire logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0]      gpio_o,
  output logic [GPIO_W-1:0]      gpio_oe_o,
  output logic                   gpio_irq_o
);

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] intr_en_q;
  logic [GPIO_W-1:0] status_q;
  logic [GPIO_W-1:0] status_d;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] prev_q;
  logic [GPIO_W-1:0] rise;
  logic [DATA_W-1:0] merged;
  logic [DATA_W-1:0] clr_mask;
  logic              wr;
  logic              irq_q;

  assign wr = reg_req_i.valid && (reg_req_i.op == REG_WRITE);

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      GPIO_IN:          reg_rsp_o.rdata[GPIO_W-1:0] = sync2_q;
      GPIO_OUT:         reg_rsp_o.rdata[GPIO_W-1:0] = out_q;
      GPIO_OE:          reg_rsp_o.rdata[GPIO_W-1:0] = oe_q;
      GPIO_INTR_EN:     reg_rsp_o.rdata[GPIO_W-1:0] = intr_en_q;
      GPIO_INTR_STATUS: reg_rsp_o.rdata[GPIO_W-1:0] = status_q;
      default:          reg_rsp_o.error = 1'b1;
    endcase
  end

  assign merged   = be_merge(reg_rsp_o.rdata, reg_req_i.wdata, reg_req_i.be);
  assign clr_mask = be_merge('0, reg_req_i.wdata, reg_req_i.be);

  // Edge seen on the synchronised level
  assign rise = sync2_q & ~prev_q;

  always_comb begin
    status_d = status_q;
    if (wr && (reg_req_i.offset == GPIO_INTR_STATUS)) begin
      status_d = status_d & ~clr_mask[GPIO_W-1:0];
    end
    status_d = status_d | (rise & intr_en_q);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      irq_q     <= 1'b0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= status_d;
      irq_q    <= |status_d;
      if (wr && (reg_req_i.offset == GPIO_OUT)) begin
        out_q <= merged[GPIO_W-1:0];
      end
      if (wr && (reg_req_i.offset == GPIO_OE)) begin
        oe_q <= merged[GPIO_W-1:0];
      end
      if (wr && (reg_req_i.offset == GPIO_INTR_EN)) begin
        intr_en_q <= merged[GPIO_W-1:0];
      end
    end
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign gpio_irq_o = irq_q;

endmodule

`default_nettype wire

/* logic/periph_irq_ctrl.sv */
// ==========================================================
// Interrupt controller with level gateways, a lowest-ID
// claim, complete by write and a software interrupt bit
// ==========================================================
`default_nettype none

module periph_irq_ctrl
  import periph_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire reg_req_t           reg_req_i,
  output reg_rsp_t                reg_rsp_o,
  input  wire logic [NUM_SRC-1:0] src_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  logic [NUM_SRC-1:0]  pending_q;
  logic [NUM_SRC-1:0]  pending_d;
  logic [NUM_SRC-1:0]  enable_q;
  logic [NUM_SRC-1:0]  enable_d;
  logic [NUM_SRC-1:0]  in_service_q;
  logic [NUM_SRC-1:0]  in_service_d;
  logic [NUM_SRC-1:0]  active;
  logic [SRC_ID_W-1:0] claim_id;
  logic [SRC_ID_W-1:0] complete_id;
  logic [DATA_W-1:0]   merged;
  logic                wr;
  logic                claim;
  logic                complete;
  logic                msip_q;
  logic                irq_q;

  assign wr       = reg_req_i.valid && (reg_req_i.op == REG_WRITE);
  assign claim    = reg_req_i.valid && (reg_req_i.op == REG_READ) &&
                    (reg_req_i.offset == IRQ_CLAIM);
  assign complete = wr && (reg_req_i.offset == IRQ_CLAIM) && reg_req_i.be[0];
  assign complete_id = reg_req_i.wdata[SRC_ID_W-1:0];

  assign active = pending_q & enable_q;

  // Lowest active ID wins and 0 means nothing to claim
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = SRC_ID_W'(i);
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      IRQ_PENDING: reg_rsp_o.rdata[NUM_SRC-1:0] = pending_q;
      IRQ_ENABLE:  reg_rsp_o.rdata[NUM_SRC-1:0] = enable_q;
      IRQ_CLAIM:   reg_rsp_o.rdata[SRC_ID_W-1:0] = claim_id;
      IRQ_MSIP:    reg_rsp_o.rdata[0] = msip_q;
      default:     reg_rsp_o.error = 1'b1;
    endcase
  end

  assign merged = be_merge(reg_rsp_o.rdata, reg_req_i.wdata, reg_req_i.be);

  always_comb begin
    // Gateway holds off a source while its ID is in service
    pending_d    = pending_q | (src_i & ~in_service_q);
    in_service_d = in_service_q;
    enable_d     = enable_q;
    if (claim && (claim_id != '0)) begin
      pending_d[claim_id]    = 1'b0;
      in_service_d[claim_id] = 1'b1;
    end
    if (complete) begin
      in_service_d[complete_id] = 1'b0;
    end
    if (wr && (reg_req_i.offset == IRQ_ENABLE)) begin
      enable_d = merged[NUM_SRC-1:0];
    end
    pending_d[0]    = 1'b0;
    in_service_d[0] = 1'b0;
    enable_d[0]     = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
      irq_q        <= 1'b0;
    end else begin
      pending_q    <= pending_d;
      enable_q     <= enable_d;
      in_service_q <= in_service_d;
      irq_q        <= |(pending_d & enable_d);
      if (wr && (reg_req_i.offset == IRQ_MSIP)) begin
        msip_q <= merged[0];
      end
    end
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
// ==========================================================
// Peripheral subsystem package with the address map, register
// offsets, bus and register structs and shared helpers
// ==========================================================
`default_nettype none

package periph_pkg;

  localparam int ADDR_W   = 12;
  localparam int DATA_W   = 32;
  localparam int BE_W     = DATA_W / 8;
  localparam int OFFSET_W = 8;
  localparam int SEL_W    = 4;
  localparam int GPIO_W   = 16;
  localparam int NUM_CMP  = 2;
  localparam int NUM_EXT  = 4;
  localparam int NUM_SRC  = 8;
  localparam int SRC_ID_W = 3;

  // Interrupt source IDs with ID 0 reserved
  localparam int SRC_GPIO   = 1;
  localparam int SRC_TIMER0 = 2;
  localparam int SRC_TIMER1 = 3;
  localparam int SRC_EXT0   = 4;

  typedef enum logic [SEL_W-1:0] {
    SEL_IRQ   = 4'h0,
    SEL_GPIO  = 4'h1,
    SEL_TIMER = 4'h2,
    SEL_NONE  = 4'hF
  } periph_sel_e;

  localparam logic [OFFSET_W-1:0] GPIO_IN          = 8'h00;
  localparam logic [OFFSET_W-1:0] GPIO_OUT         = 8'h04;
  localparam logic [OFFSET_W-1:0] GPIO_OE          = 8'h08;
  localparam logic [OFFSET_W-1:0] GPIO_INTR_EN     = 8'h0C;
  localparam logic [OFFSET_W-1:0] GPIO_INTR_STATUS = 8'h10;

  localparam logic [OFFSET_W-1:0] TMR_CTRL    = 8'h00;
  localparam logic [OFFSET_W-1:0] TMR_COUNT   = 8'h04;
  localparam logic [OFFSET_W-1:0] TMR_CMP0    = 8'h08;
  localparam logic [OFFSET_W-1:0] TMR_CMP1    = 8'h0C;
  localparam logic [OFFSET_W-1:0] TMR_INTR_EN = 8'h10;

  localparam logic [OFFSET_W-1:0] IRQ_PENDING = 8'h00;
  localparam logic [OFFSET_W-1:0] IRQ_ENABLE  = 8'h04;
  localparam logic [OFFSET_W-1:0] IRQ_CLAIM   = 8'h08;
  localparam logic [OFFSET_W-1:0] IRQ_MSIP    = 8'h0C;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic                valid;
    reg_op_e             op;
    logic [OFFSET_W-1:0] offset;
    logic [DATA_W-1:0]   wdata;
    logic [BE_W-1:0]     be;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
  } reg_rsp_t;

  // Replace only the enabled bytes of a register image
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_data,
    input logic [DATA_W-1:0] new_data,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] merged;
    merged = old_data;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* logic/periph_timer.sv */
// ==========================================================
// Timer with a 32-bit counter behind an 8-bit prescaler and
// two compare channels driving level interrupts
// ==========================================================
`default_nettype none

module periph_timer
  import periph_pkg::*;
(
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire reg_req_t       reg_req_i,
  output reg_rsp_t            reg_rsp_o,
  output logic [NUM_CMP-1:0]  timer_irq_o
);

  logic                            en_q;
  logic [7:0]                      prescale_q;
  logic [7:0]                      psc_cnt_q;
  logic [DATA_W-1:0]               count_q;
  logic [NUM_CMP-1:0][DATA_W-1:0]  cmp_q;
  logic [NUM_CMP-1:0]              intr_en_q;
  logic [NUM_CMP-1:0]              irq_q;
  logic [DATA_W-1:0]               merged;
  logic                            wr;
  logic                            tick;

  assign wr = reg_req_i.valid && (reg_req_i.op == REG_WRITE);

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (reg_req_i.offset)
      TMR_CTRL:    reg_rsp_o.rdata = {16'b0, prescale_q, 7'b0, en_q};
      TMR_COUNT:   reg_rsp_o.rdata = count_q;
      TMR_CMP0:    reg_rsp_o.rdata = cmp_q[0];
      TMR_CMP1:    reg_rsp_o.rdata = cmp_q[1];
      TMR_INTR_EN: reg_rsp_o.rdata[NUM_CMP-1:0] = intr_en_q;
      default:     reg_rsp_o.error = 1'b1;
    endcase
  end

  assign merged = be_merge(reg_rsp_o.rdata, reg_req_i.wdata, reg_req_i.be);

  // One count step every prescale+1 cycles
  assign tick = en_q && (psc_cnt_q == prescale_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q       <= 1'b0;
      prescale_q <= '0;
      psc_cnt_q  <= '0;
      count_q    <= '0;
      cmp_q      <= '0;
      intr_en_q  <= '0;
      irq_q      <= '0;
    end else begin
      if (!en_q || tick) begin
        psc_cnt_q <= '0;
      end else begin
        psc_cnt_q <= psc_cnt_q + 8'd1;
      end

      if (wr && (reg_req_i.offset == TMR_COUNT)) begin
        count_q <= merged;
      end else if (tick) begin
        count_q <= count_q + 32'd1;
      end

      if (wr && (reg_req_i.offset == TMR_CTRL)) begin
        en_q       <= merged[0];
        prescale_q <= merged[15:8];
      end
      if (wr && (reg_req_i.offset == TMR_CMP0)) begin
        cmp_q[0] <= merged;
      end
      if (wr && (reg_req_i.offset == TMR_CMP1)) begin
        cmp_q[1] <= merged;
      end
      if (wr && (reg_req_i.offset == TMR_INTR_EN)) begin
        intr_en_q <= merged[NUM_CMP-1:0];
      end

      for (int k = 0; k < NUM_CMP; k++) begin
        irq_q[k] <= intr_en_q[k] && (count_q >= cmp_q[k]);
      end
    end
  end

  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* logic/peripheral_subsystem.sv */
// ==========================================================
// Peripheral subsystem top level joining the OBI bridge,
// GPIO, timer and interrupt controller
// ==========================================================
`default_nettype none

module peripheral_subsystem
  import periph_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire obi_req_t           obi_req_i,
  output obi_rsp_t                obi_rsp_o,
  input  wire logic [GPIO_W-1:0]  gpio_i,
  output logic [GPIO_W-1:0]       gpio_o,
  output logic [GPIO_W-1:0]       gpio_oe_o,
  input  wire logic [NUM_EXT-1:0] irq_ext_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  reg_req_t           irq_req;
  reg_req_t           gpio_req;
  reg_req_t           timer_req;
  reg_rsp_t           irq_rsp;
  reg_rsp_t           gpio_rsp;
  reg_rsp_t           timer_rsp;
  logic               gpio_irq;
  logic [NUM_CMP-1:0] timer_irq;
  logic [NUM_SRC-1:0] irq_src;

  // ID 0 stays tied low
  assign irq_src[0]                   = 1'b0;
  assign irq_src[SRC_GPIO]            = gpio_irq;
  assign irq_src[SRC_TIMER0]          = timer_irq[0];
  assign irq_src[SRC_TIMER1]          = timer_irq[1];
  assign irq_src[SRC_EXT0 +: NUM_EXT] = irq_ext_i;

  periph_bus_bridge u_bridge (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_rsp_o,
    .irq_req_o   (irq_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .irq_rsp_i   (irq_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp)
  );

  periph_gpio u_gpio (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (gpio_req),
    .reg_rsp_o  (gpio_rsp),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_irq_o (gpio_irq)
  );

  periph_timer u_timer (
    .clk_i,
    .rst_n_i,
    .reg_req_i   (timer_req),
    .reg_rsp_o   (timer_rsp),
    .timer_irq_o (timer_irq)
  );

  periph_irq_ctrl u_irq_ctrl (
    .clk_i,
    .rst_n_i,
    .reg_req_i (irq_req),
    .reg_rsp_o (irq_rsp),
    .src_i     (irq_src),
    .irq_o,
    .msip_o
  );

endmodule

`default_nettype wire

/* peripheral_subsystem.f */
logic/periph_pkg.sv
logic/periph_bus_bridge.sv
logic/periph_gpio.sv
logic/periph_timer.sv
logic/periph_irq_ctrl.sv
logic/peripheral_subsystem.sv
tb/tb_peripheral_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f peripheral_subsystem.f \
  --top-module tb_peripheral_subsystem -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "FAIL"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb/tb_peripheral_subsystem.sv */
// ==========================================================
// Testbench for the peripheral subsystem with table-driven
// OBI accesses, pin and interrupt stimulus and checks
// ==========================================================
`default_nettype none

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int WAIT_LIMIT = 200;

  typedef enum logic [2:0] {
    OP_RD,
    OP_WR,
    OP_PINS,
    OP_EXT,
    OP_IDLE,
    OP_WAIT_IRQ,
    OP_CHK_OUT,
    OP_CHK_MSIP
  } tb_op_e;

  typedef struct packed {
    tb_op_e            op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] exp;
    logic              exp_err;
  } step_t;

  logic               clk;
  logic               rst_n;
  obi_req_t           obi_req;
  obi_rsp_t           obi_rsp;
  logic [GPIO_W-1:0]  gpio_in;
  logic [GPIO_W-1:0]  gpio_out;
  logic [GPIO_W-1:0]  gpio_oe;
  logic [NUM_EXT-1:0] irq_ext;
  logic               irq;
  logic               msip;

  step_t       steps[$];
  logic [15:0] lfsr_q;
  int          checks;
  int          errors;
  int          timeouts;

  peripheral_subsystem DUT (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe_o (gpio_oe),
    .irq_ext_i (irq_ext),
    .irq_o     (irq),
    .msip_o    (msip)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_word(output logic [15:0] w);
    w = '0;
    for (int b = 0; b < 16; b++) begin
      w = {w[14:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    end
  endtask

  task automatic add_step(input tb_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                          input logic exp_err);
    steps.push_back('{op, addr, wdata, exp, exp_err});
  endtask

  task automatic build_table();
    logic [15:0] w_out;
    logic [15:0] w_oe;
    logic [15:0] w_pin;
    random_word(w_out);
    random_word(w_oe);
    random_word(w_pin);
    // GPIO outputs
    add_step(OP_WR, {SEL_GPIO, GPIO_OUT}, {16'd0, w_out}, 32'd0, 1'b0);
    add_step(OP_WR, {SEL_GPIO, GPIO_OE}, {16'd0, w_oe}, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_GPIO, GPIO_OUT}, 32'd0, {16'd0, w_out}, 1'b0);
    add_step(OP_RD, {SEL_GPIO, GPIO_OE}, 32'd0, {16'd0, w_oe}, 1'b0);
    add_step(OP_CHK_OUT, 12'h000, 32'd0, {w_oe, w_out}, 1'b0);
    // Synchronised inputs and then a rising edge on pin 3
    add_step(OP_PINS, 12'h000, {16'd0, w_pin}, 32'd0, 1'b0);
    add_step(OP_IDLE, 12'h000, 32'd2, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_GPIO, GPIO_IN}, 32'd0, {16'd0, w_pin}, 1'b0);
    add_step(OP_PINS, 12'h000, 32'd0, 32'd0, 1'b0);
    add_step(OP_IDLE, 12'h000, 32'd3, 32'd0, 1'b0);
    add_step(OP_WR, {SEL_GPIO, GPIO_INTR_EN}, 32'h8, 32'd0, 1'b0);
    add_step(OP_PINS, 12'h000, 32'h8, 32'd0, 1'b0);
    add_step(OP_IDLE, 12'h000, 32'd4, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_GPIO, GPIO_INTR_STATUS}, 32'd0, 32'h8, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_ENABLE}, 32'(1 << SRC_GPIO), 32'd0, 1'b0);
    add_step(OP_WAIT_IRQ, 12'h000, 32'd0, 32'd1, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_CLAIM}, 32'd0, 32'(SRC_GPIO), 1'b0);
    add_step(OP_WR, {SEL_GPIO, GPIO_INTR_STATUS}, 32'h8, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_GPIO, GPIO_INTR_STATUS}, 32'd0, 32'd0, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_CLAIM}, 32'(SRC_GPIO), 32'd0, 1'b0);
    add_step(OP_WAIT_IRQ, 12'h000, 32'd0, 32'd0, 1'b0);
    // Stopped timer with the count already past CMP0
    add_step(OP_WR, {SEL_TIMER, TMR_COUNT}, 32'h100, 32'd0, 1'b0);
    add_step(OP_WR, {SEL_TIMER, TMR_CMP0}, 32'h80, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_TIMER, TMR_COUNT}, 32'd0, 32'h100, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_ENABLE}, 32'(1 << SRC_TIMER0), 32'd0, 1'b0);
    add_step(OP_WR, {SEL_TIMER, TMR_INTR_EN}, 32'h1, 32'd0, 1'b0);
    add_step(OP_WAIT_IRQ, 12'h000, 32'd0, 32'd1, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_CLAIM}, 32'd0, 32'(SRC_TIMER0), 1'b0);
    add_step(OP_WR, {SEL_TIMER, TMR_INTR_EN}, 32'h0, 32'd0, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_CLAIM}, 32'(SRC_TIMER0), 32'd0, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_PENDING}, 32'd0, 32'd0, 1'b0);
    // Sources 4 to 6 pend with only 4 and 6 enabled
    add_step(OP_WR, {SEL_IRQ, IRQ_ENABLE}, 32'h50, 32'd0, 1'b0);
    add_step(OP_EXT, 12'h000, 32'h7, 32'd0, 1'b0);
    add_step(OP_WAIT_IRQ, 12'h000, 32'd0, 32'd1, 1'b0);
    add_step(OP_EXT, 12'h000, 32'h0, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_PENDING}, 32'd0, 32'h70, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_CLAIM}, 32'd0, 32'd4, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_CLAIM}, 32'd4, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_CLAIM}, 32'd0, 32'd6, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_CLAIM}, 32'd6, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_CLAIM}, 32'd0, 32'd0, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_PENDING}, 32'd0, 32'h20, 1'b0);
    add_step(OP_WR, {SEL_IRQ, IRQ_MSIP}, 32'd1, 32'd0, 1'b0);
    add_step(OP_CHK_MSIP, 12'h000, 32'd0, 32'd1, 1'b0);
    add_step(OP_RD, {SEL_IRQ, IRQ_MSIP}, 32'd0, 32'd1, 1'b0);
    // Unmapped select and undefined GPIO offset
    add_step(OP_RD, 12'h300, 32'd0, 32'd0, 1'b1);
    add_step(OP_WR, 12'h300, 32'hFFFF_FFFF, 32'd0, 1'b1);
    add_step(OP_RD, 12'h114, 32'd0, 32'd0, 1'b1);
  endtask

  task automatic bus_access(input step_t s);
    int waited;
    @(posedge clk);
    obi_req <= '{req: 1'b1, we: (s.op == OP_WR), be: 4'hF, addr: s.addr, wdata: s.wdata};
    @(negedge clk);
    check_value("obi_rsp_o.gnt", 32'd1, {31'd0, obi_rsp.gnt});
    @(posedge clk);
    obi_req <= '0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!obi_rsp.rvalid && waited < WAIT_LIMIT);
    if (!obi_rsp.rvalid) begin
      timeouts++;
      $display("Timeout at %0t ns: no response for access to 0x%03h", $time, s.addr);
    end else begin
      check_value("rvalid latency", 32'd1, waited);
      check_value("obi_rsp_o.err", {31'd0, s.exp_err}, {31'd0, obi_rsp.err});
      if (s.op == OP_RD) begin
        check_value("obi_rsp_o.rdata", s.exp, obi_rsp.rdata);
      end
    end
  endtask

  task automatic wait_irq(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (irq !== level && waited < WAIT_LIMIT);
    if (irq !== level) begin
      timeouts++;
      $display("Timeout at %0t ns: irq_o never reached %0b", $time, level);
    end
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_RD, OP_WR: bus_access(s);
      OP_PINS: begin
        @(posedge clk);
        gpio_in <= s.wdata[GPIO_W-1:0];
      end
      OP_EXT: begin
        @(posedge clk);
        irq_ext <= s.wdata[NUM_EXT-1:0];
      end
      OP_IDLE: repeat (s.wdata) @(posedge clk);
      OP_WAIT_IRQ: wait_irq(s.exp[0]);
      OP_CHK_OUT: begin
        @(negedge clk);
        check_value("gpio_o", {16'd0, s.exp[15:0]}, {16'd0, gpio_out});
        check_value("gpio_oe_o", {16'd0, s.exp[31:16]}, {16'd0, gpio_oe});
      end
      default: begin
        @(negedge clk);
        check_value("msip_o", s.exp, {31'd0, msip});
      end
    endcase
  endtask

  initial begin
    rst_n   <= 1'b0;
    obi_req <= '0;
    gpio_in <= '0;
    irq_ext <= '0;
    lfsr_q   = 16'd9;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("obi_rsp_o.rvalid", 32'd0, {31'd0, obi_rsp.rvalid});
    check_value("obi_rsp_o.err", 32'd0, {31'd0, obi_rsp.err});
    check_value("gpio_o", 32'd0, {16'd0, gpio_out});
    check_value("gpio_oe_o", 32'd0, {16'd0, gpio_oe});
    check_value("irq_o", 32'd0, {31'd0, irq});
    check_value("msip_o", 32'd0, {31'd0, msip});
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
